/* flist.f */
hdl/boot_pkg.sv
hdl/cfg_loader.sv
hdl/nbf_loader.sv
hdl/load_arbiter.sv
hdl/boot_host.sv
test/tb_clock_gen.sv
test/tb_boot_host.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only if TB PASSED is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f flist.f --top-module tb_boot_host \
   --Mdir obj_dir -o tb_boot_host || exit 1

out="$(./obj_dir/tb_boot_host 2>&1)"
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1

/* test/tb_boot_host.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_boot_host;

   import boot_pkg::*;

   localparam int          NUM_CFG         = 3;
   localparam int          MAX_OUTST       = 4;
   localparam logic [39:0] FREEZE_ADDR     = 40'h00_0020_0000;
   // Records sent by the five tests sum to 1 + 20 + 6 + 5 + 1
   localparam int          NUM_RECORDS     = 33;
   localparam int          WATCHDOG_CYCLES = NUM_RECORDS * 40 + 500;

   logic        clk_i;
   logic        reset_i;
   logic        mem_cmd_ready_i = 1'b0;
   mem_resp_s   mem_resp_i = '{op: MEM_STORE, addr: '0};
   logic        mem_resp_v_i = 1'b0;
   nbf_rec_s    nbf_i = '0;
   logic        nbf_v_i = 1'b0;
   mem_cmd_s    mem_cmd_o;
   logic        mem_cmd_v_o;
   logic        nbf_ready_o;
   logic        done_o;

   // Memory model state
   mem_cmd_s    cmd_log[$];
   int          outst_log[$];
   int          due_q[$];
   logic [39:0] addr_q[$];
   int          cyc = 0;
   int          consumed_count = 0;
   logic        hold_resp = 1'b0;
   int          release_cnt = 0;

   mem_cmd_s    exp_cmds[$];
   nbf_rec_s    rec_q[$];
   int          checked_cnt = 0;
   logic [15:0] lfsr_q = 16'd73;

   tb_clock_gen u_clock_gen
      (.clk_o   (clk_i)
      ,.reset_o (reset_i)
      );

   boot_host DUT
      (.clk_i           (clk_i)
      ,.reset_i         (reset_i)
      ,.mem_cmd_o       (mem_cmd_o)
      ,.mem_cmd_v_o     (mem_cmd_v_o)
      ,.mem_cmd_ready_i (mem_cmd_ready_i)
      ,.mem_resp_i      (mem_resp_i)
      ,.mem_resp_v_i    (mem_resp_v_i)
      ,.nbf_i           (nbf_i)
      ,.nbf_v_i         (nbf_v_i)
      ,.nbf_ready_o     (nbf_ready_o)
      ,.done_o          (done_o)
      );

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++)
         v = {v[62:0], lfsr_bit()};
      return v;
   endfunction

   function automatic mem_cmd_s store_of(input logic [39:0] addr, input logic [63:0] data);
      mem_cmd_s c;
      c.op   = MEM_STORE;
      c.addr = addr;
      c.data = data;
      return c;
   endfunction

   // Core id, host did, coherence mode normal
   function automatic mem_cmd_s cfg_store(input int idx);
      case (idx)
         0:       return store_of(40'h00_0020_0008, 64'd0);
         1:       return store_of(40'h00_0020_0010, 64'd1);
         default: return store_of(40'h00_0020_0018, 64'd1);
      endcase
   endfunction

   function automatic nbf_rec_s random_write();
      nbf_rec_s r;
      r.op   = NBF_WRITE;
      r.addr = 40'(lfsr_bits(40));
      r.data = lfsr_bits(64);
      return r;
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] expected);
      if (got !== expected)
      begin
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   task automatic offer_record(input nbf_rec_s rec);
      @(posedge clk_i);
      nbf_i   <= rec;
      nbf_v_i <= 1'b1;
      @(negedge clk_i);
      while (!nbf_ready_o)
         @(negedge clk_i);
      @(posedge clk_i);
      nbf_v_i <= 1'b0;
   endtask

   task automatic send_queued();
      while (rec_q.size() > 0)
         offer_record(rec_q.pop_front());
   endtask

   task automatic compare_log();
      int i;
      while (cmd_log.size() < exp_cmds.size())
         @(negedge clk_i);
      repeat (4) @(negedge clk_i);
      check_value("command count", cmd_log.size(), exp_cmds.size());
      for (i = checked_cnt; i < exp_cmds.size(); i++)
      begin
         check_value($sformatf("cmd[%0d].op", i), cmd_log[i].op, exp_cmds[i].op);
         check_value($sformatf("cmd[%0d].addr", i), cmd_log[i].addr, exp_cmds[i].addr);
         check_value($sformatf("cmd[%0d].data", i), cmd_log[i].data, exp_cmds[i].data);
      end
      checked_cnt = exp_cmds.size();
   endtask

   task automatic wait_all_answered();
      while (consumed_count < cmd_log.size())
         @(negedge clk_i);
   endtask

   // Logs transfers, answers them after 0 to 7 cycles, toggles ready at random
   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         mem_cmd_ready_i <= 1'b0;
         mem_resp_v_i    <= 1'b0;
      end
      else
      begin
         cyc = cyc + 1;
         if (mem_resp_v_i)
            consumed_count = consumed_count + 1;
         if (mem_cmd_v_o && mem_cmd_ready_i)
         begin
            cmd_log.push_back(mem_cmd_o);
            outst_log.push_back(due_q.size() + int'(mem_resp_v_i));
            due_q.push_back(cyc + int'(lfsr_bits(3)));
            addr_q.push_back(mem_cmd_o.addr);
         end
         mem_cmd_ready_i <= lfsr_bit();
         if (due_q.size() > 0 && due_q[0] <= cyc && (!hold_resp || release_cnt > 0))
         begin
            if (hold_resp)
               release_cnt = release_cnt - 1;
            void'(due_q.pop_front());
            mem_resp_i.op   <= MEM_STORE;
            mem_resp_i.addr <= addr_q.pop_front();
            mem_resp_v_i    <= 1'b1;
         end
         else
            mem_resp_v_i <= 1'b0;
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("Timeout: the boot sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $fatal(1);
   end

   task automatic check_reset_state();
      @(negedge clk_i);
      while (reset_i)
      begin
         check_value("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
         check_value("nbf_ready_o", nbf_ready_o, 1'b0);
         check_value("done_o", done_o, 1'b0);
         @(negedge clk_i);
      end
      check_value("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
      check_value("nbf_ready_o", nbf_ready_o, 1'b0);
      check_value("done_o", done_o, 1'b0);
   endtask

   task automatic check_cfg_stores();
      nbf_rec_s rec;
      int       i;
      for (i = 0; i < NUM_CFG; i++)
         exp_cmds.push_back(cfg_store(i));
      rec = random_write();
      exp_cmds.push_back(store_of(rec.addr, rec.data));
      @(posedge clk_i);
      nbf_i   <= rec;
      nbf_v_i <= 1'b1;
      @(negedge clk_i);
      // The record has to wait until the config stores are all answered
      while (consumed_count < NUM_CFG)
      begin
         check_value("nbf_ready_o", nbf_ready_o, 1'b0);
         @(negedge clk_i);
      end
      while (!nbf_ready_o)
         @(negedge clk_i);
      @(posedge clk_i);
      nbf_v_i <= 1'b0;
      compare_log();
   endtask

   task automatic stream_writes();
      nbf_rec_s rec;
      int       n;
      for (n = 0; n < 20; n++)
      begin
         @(negedge clk_i);
         rec = random_write();
         exp_cmds.push_back(store_of(rec.addr, rec.data));
         offer_record(rec);
      end
      compare_log();
   endtask

   task automatic limit_outstanding();
      nbf_rec_s rec;
      int       base;
      int       n;
      wait_all_answered();
      hold_resp = 1'b1;
      base      = cmd_log.size();
      for (n = 0; n < 6; n++)
      begin
         rec = random_write();
         rec_q.push_back(rec);
         exp_cmds.push_back(store_of(rec.addr, rec.data));
      end
      fork
         send_queued();
         begin
            while (cmd_log.size() < base + MAX_OUTST)
               @(negedge clk_i);
            repeat (20)
            begin
               @(negedge clk_i);
               check_value("nbf_ready_o", nbf_ready_o, 1'b0);
               check_value("stores in flight", cmd_log.size() - base, MAX_OUTST);
            end
            // One answer frees exactly one credit
            release_cnt = 1;
            while (cmd_log.size() < base + MAX_OUTST + 1)
               @(negedge clk_i);
            repeat (20)
            begin
               @(negedge clk_i);
               check_value("nbf_ready_o", nbf_ready_o, 1'b0);
               check_value("stores after release", cmd_log.size() - base, MAX_OUTST + 1);
            end
            hold_resp = 1'b0;
         end
      join
      compare_log();
   endtask

   task automatic fence_drain();
      nbf_rec_s rec;
      int       base;
      int       n;
      wait_all_answered();
      hold_resp = 1'b1;
      base      = cmd_log.size();
      for (n = 0; n < 3; n++)
      begin
         rec = random_write();
         rec_q.push_back(rec);
         exp_cmds.push_back(store_of(rec.addr, rec.data));
      end
      rec.op   = NBF_FENCE;
      rec.addr = '0;
      rec.data = '0;
      rec_q.push_back(rec);
      rec = random_write();
      rec_q.push_back(rec);
      exp_cmds.push_back(store_of(rec.addr, rec.data));
      fork
         send_queued();
         begin
            while (cmd_log.size() < base + 3)
               @(negedge clk_i);
            repeat (15)
            begin
               @(negedge clk_i);
               check_value("nbf_ready_o at fence", nbf_ready_o, 1'b0);
               check_value("stores before fence", cmd_log.size() - base, 3);
            end
            hold_resp = 1'b0;
         end
      join
      compare_log();
      check_value("in flight at post-fence store", outst_log[base + 3], 0);
   endtask

   task automatic finish_boot();
      nbf_rec_s rec;
      int       base;
      @(negedge clk_i);
      base = cmd_log.size();
      exp_cmds.push_back(store_of(FREEZE_ADDR, 64'd0));
      rec.op   = NBF_FINISH;
      rec.addr = '0;
      rec.data = '0;
      offer_record(rec);
      @(negedge clk_i);
      while (cmd_log.size() < base + 1 || consumed_count < base + 1)
      begin
         check_value("done_o before freeze answer", done_o, 1'b0);
         @(negedge clk_i);
      end
      check_value("done_o", done_o, 1'b1);
      repeat (10)
      begin
         @(negedge clk_i);
         check_value("done_o held", done_o, 1'b1);
      end
      compare_log();
   endtask

   initial
   begin
      check_reset_state();
      check_cfg_stores();
      stream_writes();
      limit_outstanding();
      fence_drain();
      finish_boot();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
   (output logic clk_o
   , output logic reset_o
   );

   localparam int HALF_PERIOD_NS = 10;
   localparam int RESET_CYCLES   = 8;

   initial
   begin
      clk_o = 1'b0;
      forever
         #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   // Reset drops on a rising edge, in step with the stimulus
   initial
   begin
      reset_o <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

`default_nettype wire

/* hdl/boot_host.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_host
   (input  logic                clk_i
   , input  logic               reset_i

   , output boot_pkg::mem_cmd_s  mem_cmd_o
   , output logic               mem_cmd_v_o
   , input  logic               mem_cmd_ready_i

   , input  boot_pkg::mem_resp_s mem_resp_i
   , input  logic               mem_resp_v_i

   , input  boot_pkg::nbf_rec_s  nbf_i
   , input  logic               nbf_v_i
   , output logic               nbf_ready_o

   , output logic               done_o
   );

   import boot_pkg::*;

   mem_cmd_s cfg_cmd;
   logic     cfg_cmd_v;
   logic     cfg_cmd_ready;
   logic     cfg_resp_v;
   logic     cfg_done;

   mem_cmd_s nbf_cmd;
   logic     nbf_cmd_v;
   logic     nbf_cmd_ready;
   logic     nbf_resp_v;

   cfg_loader u_cfg_loader
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.cmd_o        (cfg_cmd)
      ,.cmd_v_o      (cfg_cmd_v)
      ,.cmd_ready_i  (cfg_cmd_ready)
      ,.resp_v_i     (cfg_resp_v)
      ,.done_o       (cfg_done)
      );

   nbf_loader u_nbf_loader
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.rec_i        (nbf_i)
      ,.rec_v_i      (nbf_v_i)
      ,.rec_ready_o  (nbf_ready_o)
      ,.cmd_o        (nbf_cmd)
      ,.cmd_v_o      (nbf_cmd_v)
      ,.cmd_ready_i  (nbf_cmd_ready)
      ,.resp_v_i     (nbf_resp_v)
      ,.done_o       (done_o)
      );

   load_arbiter u_load_arbiter
      (.cfg_done_i      (cfg_done)
      ,.cfg_cmd_i       (cfg_cmd)
      ,.cfg_cmd_v_i     (cfg_cmd_v)
      ,.cfg_cmd_ready_o (cfg_cmd_ready)
      ,.cfg_resp_v_o    (cfg_resp_v)
      ,.nbf_cmd_i       (nbf_cmd)
      ,.nbf_cmd_v_i     (nbf_cmd_v)
      ,.nbf_cmd_ready_o (nbf_cmd_ready)
      ,.nbf_resp_v_o    (nbf_resp_v)
      ,.mem_cmd_o       (mem_cmd_o)
      ,.mem_cmd_v_o     (mem_cmd_v_o)
      ,.mem_cmd_ready_i (mem_cmd_ready_i)
      ,.mem_resp_v_i    (mem_resp_v_i)
      );

   // A stalled command holds across the hand-over between loaders
   cmd_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (mem_cmd_v_o && !mem_cmd_ready_i) |=> (mem_cmd_v_o && $stable(mem_cmd_o)));

   // Only stores are ever issued, so only stores come back
   resp_is_store_a: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_i |-> (mem_resp_i.op == MEM_STORE));

endmodule

`default_nettype wire

/* hdl/load_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module load_arbiter
   (input  logic               cfg_done_i

   , input  boot_pkg::mem_cmd_s cfg_cmd_i
   , input  logic              cfg_cmd_v_i
   , output logic              cfg_cmd_ready_o
   , output logic              cfg_resp_v_o

   , input  boot_pkg::mem_cmd_s nbf_cmd_i
   , input  logic              nbf_cmd_v_i
   , output logic              nbf_cmd_ready_o
   , output logic              nbf_resp_v_o

   , output boot_pkg::mem_cmd_s mem_cmd_o
   , output logic              mem_cmd_v_o
   , input  logic              mem_cmd_ready_i
   , input  logic              mem_resp_v_i
   );

   // Fixed priority, the config loader owns the link until it is done
   always_comb
   begin
      if (!cfg_done_i)
      begin
         mem_cmd_o       = cfg_cmd_i;
         mem_cmd_v_o     = cfg_cmd_v_i;
         cfg_cmd_ready_o = mem_cmd_ready_i;
         nbf_cmd_ready_o = 1'b0;
         cfg_resp_v_o    = mem_resp_v_i;
         nbf_resp_v_o    = 1'b0;
      end
      else
      begin
         mem_cmd_o       = nbf_cmd_i;
         mem_cmd_v_o     = nbf_cmd_v_i;
         cfg_cmd_ready_o = 1'b0;
         nbf_cmd_ready_o = mem_cmd_ready_i;
         cfg_resp_v_o    = 1'b0;
         nbf_resp_v_o    = mem_resp_v_i;
      end
   end

endmodule

`default_nettype wire

/* hdl/nbf_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module nbf_loader
   (input  logic               clk_i
   , input  logic              reset_i

   , input  boot_pkg::nbf_rec_s rec_i
   , input  logic              rec_v_i
   , output logic              rec_ready_o

   , output boot_pkg::mem_cmd_s cmd_o
   , output logic              cmd_v_o
   , input  logic              cmd_ready_i

   , input  logic              resp_v_i

   , output logic              done_o
   );

   import boot_pkg::*;

   typedef enum logic [1:0]
   {
      LOAD,
      FREEZE_CLEAR,
      DRAIN,
      DONE
   } state_e;

   state_e                 state_r;
   state_e                 state_n;
   logic [OUTST_WIDTH-1:0] outst_r;
   logic [OUTST_WIDTH-1:0] outst_n;
   logic                   has_room;
   logic                   cmd_fire;
   logic                   rec_fire;

   assign has_room = (outst_r < OUTST_WIDTH'(NBF_MAX_OUTSTANDING));
   assign cmd_fire = cmd_v_o & cmd_ready_i;
   assign rec_fire = rec_v_i & rec_ready_o;
   assign done_o   = (state_r == DONE);

   always_comb
   begin
      cmd_o.op    = MEM_STORE;
      cmd_o.addr  = rec_i.addr;
      cmd_o.data  = rec_i.data;
      cmd_v_o     = 1'b0;
      rec_ready_o = 1'b0;
      case (state_r)
         LOAD:
         begin
            cmd_v_o = rec_v_i & (rec_i.op == NBF_WRITE) & has_room;
            // Records only move while the link would take a store
            case (rec_i.op)
               NBF_WRITE:  rec_ready_o = cmd_v_o & cmd_ready_i;
               NBF_FENCE:  rec_ready_o = rec_v_i & cmd_ready_i & (outst_r == '0);
               NBF_FINISH: rec_ready_o = rec_v_i & cmd_ready_i & has_room;
               default:    rec_ready_o = 1'b0;
            endcase
         end
         FREEZE_CLEAR:
         begin
            // Release the core only after all program stores landed
            cmd_o.addr = CFG_FREEZE_ADDR;
            cmd_o.data = '0;
            cmd_v_o    = (outst_r == '0);
         end
         default:
         begin
            cmd_v_o = 1'b0;
         end
      endcase
   end

   always_comb
   begin
      state_n = state_r;
      outst_n = outst_r;
      if (cmd_fire)
         outst_n = outst_n + 1'b1;
      if (resp_v_i)
         outst_n = outst_n - 1'b1;
      case (state_r)
         LOAD:
            if (rec_fire && (rec_i.op == NBF_FINISH))
               state_n = FREEZE_CLEAR;
         FREEZE_CLEAR:
            if (cmd_fire)
               state_n = DRAIN;
         DRAIN:
            if (outst_n == '0)
               state_n = DONE;
         default:
            state_n = DONE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= LOAD;
         outst_r <= '0;
      end
      else
      begin
         state_r <= state_n;
         outst_r <= outst_n;
      end
   end

   outst_limit_a: assert property (@(posedge clk_i) disable iff (reset_i)
      outst_r <= OUTST_WIDTH'(NBF_MAX_OUTSTANDING));

endmodule

`default_nettype wire

/* hdl/cfg_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_loader
   (input  logic               clk_i
   , input  logic              reset_i

   , output boot_pkg::mem_cmd_s cmd_o
   , output logic              cmd_v_o
   , input  logic              cmd_ready_i

   , input  logic              resp_v_i

   , output logic              done_o
   );

   import boot_pkg::*;

   logic [$clog2(CFG_NUM_WRITES+1)-1:0] idx_r;
   logic [$clog2(CFG_NUM_WRITES+1)-1:0] idx_n;
   logic [$clog2(CFG_NUM_WRITES+1)-1:0] tbl_idx;
   logic [OUTST_WIDTH-1:0]              outst_r;
   logic [OUTST_WIDTH-1:0]              outst_n;
   logic                                cmd_v_r;
   logic                                done_r;
   logic                                cmd_fire;

   assign cmd_fire = cmd_v_r & cmd_ready_i;
   assign cmd_v_o  = cmd_v_r;
   assign done_o   = done_r;

   // Keep the table lookup in range once every entry has gone out
   assign tbl_idx = (idx_r < CFG_NUM_WRITES) ? idx_r : '0;

   always_comb
   begin
      cmd_o.op   = MEM_STORE;
      cmd_o.addr = CFG_ADDR_TABLE[tbl_idx];
      cmd_o.data = CFG_DATA_TABLE[tbl_idx];
   end

   always_comb
   begin
      idx_n   = idx_r;
      outst_n = outst_r;
      if (cmd_fire)
      begin
         idx_n   = idx_r + 1'b1;
         outst_n = outst_n + 1'b1;
      end
      if (resp_v_i)
      begin
         outst_n = outst_n - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         idx_r   <= '0;
         outst_r <= '0;
         cmd_v_r <= 1'b0;
         done_r  <= 1'b0;
      end
      else
      begin
         idx_r   <= idx_n;
         outst_r <= outst_n;
         // Valid stays up back to back while table entries remain
         cmd_v_r <= (idx_n < CFG_NUM_WRITES);
         // Done once the whole table is sent and answered
         done_r  <= done_r | ((idx_n == CFG_NUM_WRITES) & (outst_n == '0));
      end
   end

   // Every response must belong to a store that is still in flight
   resp_has_owner_a: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_i |-> (outst_r != '0));

endmodule

`default_nettype wire

/* hdl/boot_pkg.sv */
`default_nettype none

package boot_pkg;

   // Physical address and data widths of the memory-command link
   localparam int ADDR_WIDTH = 40;
   localparam int DATA_WIDTH = 64;

   typedef enum logic [1:0]
   {
      MEM_LOAD  = 2'b00,
      MEM_STORE = 2'b01
   } mem_op_e;

   // Boot record opcodes
   typedef enum logic [1:0]
   {
      NBF_WRITE  = 2'b00,
      NBF_FENCE  = 2'b01,
      NBF_FINISH = 2'b10
   } nbf_op_e;

   typedef struct packed
   {
      mem_op_e                 op;
      logic [ADDR_WIDTH-1:0]   addr;
      logic [DATA_WIDTH-1:0]   data;
   } mem_cmd_s;

   // Responses carry no data, the loaders only count them
   typedef struct packed
   {
      mem_op_e                 op;
      logic [ADDR_WIDTH-1:0]   addr;
   } mem_resp_s;

   typedef struct packed
   {
      nbf_op_e                 op;
      logic [ADDR_WIDTH-1:0]   addr;
      logic [DATA_WIDTH-1:0]   data;
   } nbf_rec_s;

   localparam int CFG_NUM_WRITES = 3;

   // Entry 0 sits in the low slice: core id, host did, coherence mode
   localparam logic [CFG_NUM_WRITES-1:0][ADDR_WIDTH-1:0] CFG_ADDR_TABLE =
      {40'h00_0020_0018, 40'h00_0020_0010, 40'h00_0020_0008};

   // Coherence mode 1 selects normal operation
   localparam logic [CFG_NUM_WRITES-1:0][DATA_WIDTH-1:0] CFG_DATA_TABLE =
      {64'd1, 64'd1, 64'd0};

   // Freeze register, writing 0 lets the core run
   localparam logic [ADDR_WIDTH-1:0] CFG_FREEZE_ADDR = 40'h00_0020_0000;

   // Store credits of the NBF loader
   localparam int NBF_MAX_OUTSTANDING = 4;
   localparam int OUTST_WIDTH         = 3;

endpackage

`default_nettype wire
